// ==== Bender.yml ====
package:
  name: snowbro2_main_bus

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/snowbro2_pkg.sv
      - rtl/cpu_bus_if.sv
      - rtl/cen_divider.sv
      - rtl/bus_cycle_fsm.sv
      - rtl/addr_decode.sv
      - rtl/dual_ram16.sv
      - rtl/vdp_cmd.sv
      - rtl/snowbro2_main_bus.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - tb/snowbro2_bus_sva.sv
      - tb/tb_snowbro2_bus.sv

// ==== compile.f ====
+incdir+rtl
rtl/snowbro2_pkg.sv
rtl/cpu_bus_if.sv
rtl/cen_divider.sv
rtl/bus_cycle_fsm.sv
rtl/addr_decode.sv
rtl/dual_ram16.sv
rtl/vdp_cmd.sv
rtl/snowbro2_main_bus.sv
tb/snowbro2_bus_sva.sv
tb/tb_snowbro2_bus.sv

// ==== rtl/addr_decode.sv ====
/* address decode and read mux */
`timescale 1ns/1ns
`default_nettype none
`include "snowbro2_defs.svh"

module addr_decode (
    input  wire                    clk96,
    input  wire                    reset96,
    cpu_bus_if.slave               bus,
    input  wire                    commit,
    output snowbro2_pkg::region_t  region,
    output logic                   dev_ready,
    output logic                   prg_cs,
    output logic [18:0]            prg_addr,
    input  wire  [15:0]            prg_data,
    input  wire                    prg_ok,
    input  wire  [15:0]            vdp_dout,
    input  wire                    vdp_ack,
    input  wire  [9:0]             joystick1,
    input  wire  [9:0]             joystick2,
    input  wire  [1:0]             start_button,
    input  wire  [1:0]             coin_input,
    input  wire                    service,
    input  wire                    dip_test,
    input  wire  [7:0]             dipsw_a,
    input  wire  [7:0]             dipsw_b,
    input  wire  [7:0]             dipsw_c,
    output logic [1:0]             wram_we,
    output logic [`WRAM_AW-1:0]    wram_addr,
    input  wire  [15:0]            wram_q,
    output logic [1:0]             pal_we,
    output logic [`PAL_AW-1:0]     pal_addr,
    input  wire  [15:0]            pal_q,
    output logic [15:0]            cpu_din
);

    logic [23:0] addr_8;
    logic [7:0]  p1_byte;
    logic [7:0]  p2_byte;
    logic [7:0]  sys_byte;
    logic [15:0] rd_data;
    logic [1:0]  lane_we;
    logic        cycle_done;

    assign addr_8 = {bus.addr, 1'b0};   // byte address, easier to follow the map

    always_comb begin
        if (addr_8 <= `ROM_TOP)                   region = snowbro2_pkg::REG_ROM;
        else if (addr_8[23:16] == `WRAM_BASE)     region = snowbro2_pkg::REG_WRAM;
        else if (addr_8[23:20] == `VDP_BASE)      region = snowbro2_pkg::REG_VDP;
        else if (addr_8[23:20] == `PAL_BASE)      region = snowbro2_pkg::REG_PAL;
        else if (addr_8[23:12] == `IO_BASE)       region = snowbro2_pkg::REG_IO;
        else                                      region = snowbro2_pkg::REG_NONE;
    end

    always_comb begin
        case (region)
            snowbro2_pkg::REG_ROM: dev_ready = prg_cs && prg_ok;
            snowbro2_pkg::REG_VDP: dev_ready = vdp_ack;
            default:               dev_ready = 1'b1;
        endcase
    end

    // byte lanes, only on the commit edge of a write
    assign lane_we   = {2{commit && !bus.rw}} & ~{bus.uds_n, bus.lds_n};
    assign wram_we   = (region == snowbro2_pkg::REG_WRAM) ? lane_we : 2'b00;
    assign pal_we    = (region == snowbro2_pkg::REG_PAL)  ? lane_we : 2'b00;
    assign wram_addr = bus.addr[`WRAM_AW:1];
    assign pal_addr  = bus.addr[`PAL_AW:1];

    // cabinet inputs are active low
    assign p1_byte  = {2'b00, ~joystick1[5], ~joystick1[4],
                       ~joystick1[0], ~joystick1[1], ~joystick1[2], ~joystick1[3]};
    assign p2_byte  = {2'b00, ~joystick2[5], ~joystick2[4],
                       ~joystick2[0], ~joystick2[1], ~joystick2[2], ~joystick2[3]};
    assign sys_byte = {1'b0, ~start_button[1], ~start_button[0], ~coin_input[1],
                       ~coin_input[0], ~dip_test, 1'b0, ~service};

    always_comb begin
        rd_data = 16'h0000;
        case (region)
            snowbro2_pkg::REG_ROM:  rd_data = prg_data;
            snowbro2_pkg::REG_WRAM: rd_data = wram_q;
            snowbro2_pkg::REG_PAL:  rd_data = pal_q;
            snowbro2_pkg::REG_VDP:  rd_data = vdp_dout;
            snowbro2_pkg::REG_IO: begin
                case (addr_8[11:0])
                    `IO_JMPR: rd_data = {2{dipsw_c}};
                    `IO_DSWA: rd_data = {2{dipsw_a}};
                    `IO_DSWB: rd_data = {2{dipsw_b}};
                    `IO_IN1:  rd_data = {2{p1_byte}};
                    `IO_IN2:  rd_data = {2{p2_byte}};
                    `IO_SYS:  rd_data = {8'h00, sys_byte};
                    default:  rd_data = 16'h0000;
                endcase
            end
            default: rd_data = 16'h0000;
        endcase
    end

    always_ff @(posedge clk96 or posedge reset96) begin
        if (reset96) begin
            cpu_din    <= 16'h0000;
            prg_cs     <= 1'b0;
            cycle_done <= 1'b0;
        end else begin
            if (commit && bus.rw) cpu_din <= rd_data;
            if (bus.as_n) cycle_done <= 1'b0;
            else if (commit) cycle_done <= 1'b1;
            // request stays up until the cycle commits
            prg_cs <= !bus.as_n && (region == snowbro2_pkg::REG_ROM) && !commit && !cycle_done;
        end
    end

    always_ff @(posedge clk96) begin
        if (!bus.as_n) prg_addr <= bus.addr[19:1];
    end

endmodule

`default_nettype wire

// ==== rtl/bus_cycle_fsm.sv ====
/* bus cycle control */
`timescale 1ns/1ns
`default_nettype none

module bus_cycle_fsm (
    input  wire                   clk96,
    input  wire                   reset96,
    cpu_bus_if.slave              bus,
    input  wire                   cen16,
    input  snowbro2_pkg::region_t region,
    input  wire                   dev_ready,
    output wire                   dtack_n,
    output wire                   commit
);

    snowbro2_pkg::bus_state_t state;
    snowbro2_pkg::bus_state_t state_nx;

    // one pulse at the edge where DTACK falls
    assign commit  = (state == snowbro2_pkg::ST_WAIT) && cen16 && dev_ready;
    assign dtack_n = (state != snowbro2_pkg::ST_ACK);

    always_comb begin
        state_nx = state;
        case (state)
            snowbro2_pkg::ST_IDLE: begin
                if (!bus.as_n) begin
                    state_nx = snowbro2_pkg::ST_DECODE;
                end
            end
            snowbro2_pkg::ST_DECODE: begin
                if (bus.as_n) begin
                    state_nx = snowbro2_pkg::ST_IDLE;      // cycle dropped
                end else if (region != snowbro2_pkg::REG_NONE || bus.rw) begin
                    state_nx = snowbro2_pkg::ST_WAIT;      // unmapped reads ack as zero
                end
            end
            snowbro2_pkg::ST_WAIT: begin
                if (commit) begin
                    state_nx = snowbro2_pkg::ST_ACK;
                end
            end
            snowbro2_pkg::ST_ACK: begin
                // hold dtack until the master ends the cycle
                if (bus.as_n) begin
                    state_nx = snowbro2_pkg::ST_IDLE;
                end
            end
            default: state_nx = snowbro2_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk96 or posedge reset96) begin
        if (reset96) begin
            state <= snowbro2_pkg::ST_IDLE;
        end else begin
            state <= state_nx;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/cen_divider.sv ====
/* 16 MHz clock enables */
`timescale 1ns/1ns
`default_nettype none
`include "snowbro2_defs.svh"

module cen_divider (
    input  wire clk96,
    input  wire reset96,
    output wire cen16,
    output wire cen16b
);

    localparam int HALF = `CEN_DEN / 2;

    logic [4:0] cnt;
    logic [4:0] sum;

    assign sum = cnt + 5'(`CEN_NUM);

    // cen16 on wrap, cen16b when crossing half a period
    assign cen16  = (sum >= 5'(`CEN_DEN));
    assign cen16b = (cnt < 5'(HALF)) && (sum >= 5'(HALF));

    always_ff @(posedge clk96 or posedge reset96) begin
        if (reset96) begin
            // preset so the first cycle after reset wraps
            cnt <= 5'(`CEN_DEN - `CEN_NUM);
        end else if (cen16) begin
            cnt <= sum - 5'(`CEN_DEN);
        end else begin
            cnt <= sum;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/cpu_bus_if.sv ====
/* 68000 bus signals */
`timescale 1ns/1ns
`default_nettype none

interface cpu_bus_if;
    logic [23:1] addr;     // word address
    logic [15:0] wdata;
    logic        rw;       // 1 = read
    logic        uds_n;
    logic        lds_n;
    logic        as_n;

    modport master (
        output addr,
        output wdata,
        output rw,
        output uds_n,
        output lds_n,
        output as_n
    );

    modport slave (
        input addr,
        input wdata,
        input rw,
        input uds_n,
        input lds_n,
        input as_n
    );
endinterface

`default_nettype wire

// ==== rtl/dual_ram16.sv ====
/* dual port 16-bit RAM */
`timescale 1ns/1ns
`default_nettype none

module dual_ram16 #(
    parameter int aw = 11
) (
    input  wire          clk96,
    input  wire [aw-1:0] addr0,
    input  wire [15:0]   wdata0,
    input  wire [1:0]    we0,     // {upper, lower}
    output logic [15:0]  q0,
    input  wire [aw-1:0] addr1,
    output logic [15:0]  q1
);

    logic [15:0] mem [0:(1<<aw)-1];

    always_ff @(posedge clk96) begin
        if (we0[1]) mem[addr0][15:8] <= wdata0[15:8];
        if (we0[0]) mem[addr0][7:0]  <= wdata0[7:0];
        q0 <= mem[addr0];
    end

    // second port is read only
    always_ff @(posedge clk96) begin
        q1 <= mem[addr1];
    end

endmodule

`default_nettype wire

// ==== rtl/snowbro2_defs.svh ====
/* main bus address map and clock enables */
`ifndef SNOWBRO2_DEFS_SVH
`define SNOWBRO2_DEFS_SVH

// byte address compares
`define ROM_TOP     24'h07FFFF
`define WRAM_BASE   8'h10       // bits 23:16
`define VDP_BASE    4'h3        // bits 23:20
`define PAL_BASE    4'h4        // bits 23:20
`define IO_BASE     12'h700     // bits 23:12

// offsets inside the I/O page
`define IO_JMPR     12'h000
`define IO_DSWA     12'h004
`define IO_DSWB     12'h008
`define IO_IN1      12'h00C
`define IO_IN2      12'h010
`define IO_SYS      12'h01C
`define IO_OKIBANK  12'h030

`define CEN_NUM     1           // 16 MHz out of 96 MHz
`define CEN_DEN     6

`define WRAM_AW     15
`define PAL_AW      11

`endif

// ==== rtl/snowbro2_main_bus.sv ====
/* snow bros 2 main CPU bus */
`timescale 1ns/1ns
`default_nettype none
`include "snowbro2_defs.svh"

module snowbro2_main_bus (
    input  wire                 clk96,
    input  wire                 reset96,
    input  wire  [23:1]         cpu_addr,
    input  wire  [15:0]         cpu_wdata,
    input  wire                 cpu_rw,
    input  wire                 cpu_as_n,
    input  wire                 cpu_uds_n,
    input  wire                 cpu_lds_n,
    output wire  [15:0]         cpu_din,
    output wire                 dtack_n,
    output wire                 cen16,
    output wire                 cen16b,
    // program ROM
    output wire                 prg_cs,
    output wire  [18:0]         prg_addr,
    input  wire  [15:0]         prg_data,
    input  wire                 prg_ok,
    // VDP
    output wire                 vdp_op_set_ptr,
    output wire                 vdp_op_sel_reg,
    output wire                 vdp_op_wr_reg,
    output wire                 vdp_op_wr_ram,
    output wire                 vdp_op_rd_ram_h,
    output wire                 vdp_op_rd_ram_l,
    input  wire  [15:0]         vdp_dout,
    input  wire                 vdp_ack,
    // cabinet and DIP switches
    input  wire  [9:0]          joystick1,
    input  wire  [9:0]          joystick2,
    input  wire  [1:0]          start_button,
    input  wire  [1:0]          coin_input,
    input  wire                 service,
    input  wire                 dip_test,
    input  wire  [7:0]          dipsw_a,
    input  wire  [7:0]          dipsw_b,
    input  wire  [7:0]          dipsw_c,
    input  wire  [`PAL_AW-1:0]  palram_addr,
    output wire  [15:0]         palram_data,
    output wire                 oki_bank
);

    cpu_bus_if bus ();

    snowbro2_pkg::region_t region;
    wire                   dev_ready;
    wire                   commit;
    wire [1:0]             wram_we;
    wire [1:0]             pal_we;
    wire [`WRAM_AW-1:0]    wram_addr;
    wire [`PAL_AW-1:0]     pal_addr;
    wire [15:0]            wram_q;
    wire [15:0]            pal_q;

    assign bus.addr  = cpu_addr;
    assign bus.wdata = cpu_wdata;
    assign bus.rw    = cpu_rw;
    assign bus.uds_n = cpu_uds_n;
    assign bus.lds_n = cpu_lds_n;
    assign bus.as_n  = cpu_as_n;

    cen_divider u_cen (
        .clk96(clk96), .reset96(reset96), .cen16(cen16), .cen16b(cen16b)
    );

    bus_cycle_fsm u_fsm (
        .clk96(clk96), .reset96(reset96), .bus(bus.slave), .cen16(cen16),
        .region(region), .dev_ready(dev_ready), .dtack_n(dtack_n), .commit(commit)
    );

    addr_decode u_dec (
        .clk96(clk96), .reset96(reset96), .bus(bus.slave), .commit(commit),
        .region(region), .dev_ready(dev_ready),
        .prg_cs(prg_cs), .prg_addr(prg_addr), .prg_data(prg_data), .prg_ok(prg_ok),
        .vdp_dout(vdp_dout), .vdp_ack(vdp_ack),
        .joystick1(joystick1), .joystick2(joystick2), .start_button(start_button),
        .coin_input(coin_input), .service(service), .dip_test(dip_test),
        .dipsw_a(dipsw_a), .dipsw_b(dipsw_b), .dipsw_c(dipsw_c),
        .wram_we(wram_we), .wram_addr(wram_addr), .wram_q(wram_q),
        .pal_we(pal_we), .pal_addr(pal_addr), .pal_q(pal_q),
        .cpu_din(cpu_din)
    );

    // work RAM 0x100000-0x10FFFF, CPU side only
    dual_ram16 #(.aw(`WRAM_AW)) u_wram (
        .clk96(clk96), .addr0(wram_addr), .wdata0(cpu_wdata), .we0(wram_we),
        .q0(wram_q), .addr1(wram_addr), .q1()
    );

    // palette RAM 0x400000 page, port 1 feeds the video side
    dual_ram16 #(.aw(`PAL_AW)) u_palram (
        .clk96(clk96), .addr0(pal_addr), .wdata0(cpu_wdata), .we0(pal_we),
        .q0(pal_q), .addr1(palram_addr), .q1(palram_data)
    );

    vdp_cmd u_vdp (
        .clk96(clk96), .reset96(reset96), .bus(bus.slave), .commit(commit),
        .region(region), .vdp_ack(vdp_ack),
        .vdp_op_set_ptr(vdp_op_set_ptr), .vdp_op_sel_reg(vdp_op_sel_reg),
        .vdp_op_wr_reg(vdp_op_wr_reg), .vdp_op_wr_ram(vdp_op_wr_ram),
        .vdp_op_rd_ram_h(vdp_op_rd_ram_h), .vdp_op_rd_ram_l(vdp_op_rd_ram_l),
        .oki_bank(oki_bank)
    );

endmodule

`default_nettype wire

// ==== rtl/snowbro2_pkg.sv ====
/* main bus types */
`default_nettype none

package snowbro2_pkg;

    // device selected by the current address
    typedef enum logic [2:0] {
        REG_NONE,
        REG_ROM,
        REG_WRAM,
        REG_VDP,
        REG_PAL,
        REG_IO
    } region_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_DECODE,
        ST_WAIT,
        ST_ACK
    } bus_state_t;

    typedef enum logic [2:0] {
        OP_NONE,
        OP_SET_PTR,
        OP_SEL_REG,
        OP_WR_REG,
        OP_WR_RAM,
        OP_RD_RAM_H,
        OP_RD_RAM_L
    } vdp_op_t;

endpackage

`default_nettype wire

// ==== rtl/vdp_cmd.sv ====
/* VDP command strobes */
`timescale 1ns/1ns
`default_nettype none
`include "snowbro2_defs.svh"

module vdp_cmd (
    input  wire                   clk96,
    input  wire                   reset96,
    cpu_bus_if.slave              bus,
    input  wire                   commit,
    input  snowbro2_pkg::region_t region,
    input  wire                   vdp_ack,
    output logic                  vdp_op_set_ptr,
    output logic                  vdp_op_sel_reg,
    output logic                  vdp_op_wr_reg,
    output logic                  vdp_op_wr_ram,
    output logic                  vdp_op_rd_ram_h,
    output logic                  vdp_op_rd_ram_l,
    output logic                  oki_bank
);

    snowbro2_pkg::vdp_op_t op;
    logic [3:0]  vdp_off;
    logic [11:0] io_off;
    logic        vdp_hit;

    assign vdp_off = {bus.addr[3:1], 1'b0};
    assign io_off  = {bus.addr[11:1], 1'b0};
    assign vdp_hit = commit && (region == snowbro2_pkg::REG_VDP);

    always_comb begin
        op = snowbro2_pkg::OP_NONE;
        if (!bus.rw) begin
            case (vdp_off)
                4'h0:       op = snowbro2_pkg::OP_SET_PTR;
                4'h4, 4'h6: op = snowbro2_pkg::OP_WR_RAM;
                4'h8:       op = snowbro2_pkg::OP_SEL_REG;
                4'hC:       op = snowbro2_pkg::OP_WR_REG;
                default:    op = snowbro2_pkg::OP_NONE;
            endcase
        end else begin
            case (vdp_off)
                4'h4:    op = snowbro2_pkg::OP_RD_RAM_H;
                4'h6:    op = snowbro2_pkg::OP_RD_RAM_L;
                default: op = snowbro2_pkg::OP_NONE;
            endcase
        end
    end

    always_ff @(posedge clk96 or posedge reset96) begin
        if (reset96) begin
            vdp_op_set_ptr  <= 1'b0;
            vdp_op_sel_reg  <= 1'b0;
            vdp_op_wr_reg   <= 1'b0;
            vdp_op_wr_ram   <= 1'b0;
            vdp_op_rd_ram_h <= 1'b0;
            vdp_op_rd_ram_l <= 1'b0;
            oki_bank        <= 1'b0;
        end else begin
            if (vdp_hit) begin
                // new command replaces any pending one
                vdp_op_set_ptr  <= (op == snowbro2_pkg::OP_SET_PTR);
                vdp_op_sel_reg  <= (op == snowbro2_pkg::OP_SEL_REG);
                vdp_op_wr_reg   <= (op == snowbro2_pkg::OP_WR_REG);
                vdp_op_wr_ram   <= (op == snowbro2_pkg::OP_WR_RAM);
                vdp_op_rd_ram_h <= (op == snowbro2_pkg::OP_RD_RAM_H);
                vdp_op_rd_ram_l <= (op == snowbro2_pkg::OP_RD_RAM_L);
            end else if (vdp_ack) begin
                vdp_op_set_ptr  <= 1'b0;
                vdp_op_sel_reg  <= 1'b0;
                vdp_op_wr_reg   <= 1'b0;
                vdp_op_wr_ram   <= 1'b0;
                vdp_op_rd_ram_h <= 1'b0;
                vdp_op_rd_ram_l <= 1'b0;
            end
            if (commit && !bus.rw && !bus.lds_n && region == snowbro2_pkg::REG_IO
                    && io_off == `IO_OKIBANK) begin
                oki_bank <= bus.wdata[0];   // sample ROM bank
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb/snowbro2_bus_sva.sv ====
/* bus cycle protocol assertions */
`timescale 1ns/1ns
`default_nettype none

module snowbro2_bus_sva (
    input wire                      clk96,
    input wire                      reset96,
    input wire                      as_n,
    input wire                      cen16,
    input wire                      dtack_n,
    input wire                      commit,
    input snowbro2_pkg::bus_state_t state
);

    // dtack must let go once the master has ended the cycle
    a_dtack_release: assert property (@(posedge clk96) disable iff (reset96)
        (as_n && $past(as_n)) |-> dtack_n)
        else $error("dtack_n low with as_n high for two cycles");

    a_commit_pulse: assert property (@(posedge clk96) disable iff (reset96)
        commit |=> !commit)
        else $error("commit longer than one cycle");

    a_wait_on_cen: assert property (@(posedge clk96) disable iff (reset96)
        (state == snowbro2_pkg::ST_WAIT && !cen16) |=> state == snowbro2_pkg::ST_WAIT)
        else $error("ST_WAIT left without cen16");

    a_reset_dtack: assert property (@(posedge clk96) reset96 |-> dtack_n)
        else $error("dtack_n low during reset");

endmodule

bind bus_cycle_fsm snowbro2_bus_sva u_sva (
    .clk96(clk96), .reset96(reset96), .as_n(bus.as_n), .cen16(cen16),
    .dtack_n(dtack_n), .commit(commit), .state(state)
);

`default_nettype wire

// ==== tb/tb_snowbro2_bus.sv ====
/* main bus testbench */
`timescale 1ns/1ns
`default_nettype none
`include "snowbro2_defs.svh"

module tb_snowbro2_bus;

    logic               clk96;
    logic               reset96;
    logic [23:1]        cpu_addr;
    logic [15:0]        cpu_wdata;
    logic               cpu_rw;
    logic               cpu_as_n;
    logic               cpu_uds_n;
    logic               cpu_lds_n;
    wire  [15:0]        cpu_din;
    wire                dtack_n;
    wire                cen16;
    wire                cen16b;
    wire                prg_cs;
    wire  [18:0]        prg_addr;
    logic [15:0]        prg_data;
    logic               prg_ok;
    wire  [5:0]         strobes;  // set_ptr sel_reg wr_reg wr_ram rd_h rd_l
    logic [15:0]        vdp_dout;
    logic               vdp_ack;
    logic [9:0]         joystick1;
    logic [9:0]         joystick2;
    logic [1:0]         start_button;
    logic [1:0]         coin_input;
    logic               service;
    logic               dip_test;
    logic [7:0]         dipsw_a;
    logic [7:0]         dipsw_b;
    logic [7:0]         dipsw_c;
    logic [`PAL_AW-1:0] palram_addr;
    wire  [15:0]        palram_data;
    wire                oki_bank;

    int          errors;
    int          checks;
    int          rom_delay;
    int          vdp_delay;
    logic [15:0] rom_model [int];
    logic [15:0] wram_model [int];
    logic [15:0] pal_model [int];
    logic        oki_model;
    logic [18:0] last_prg_addr;
    logic [5:0]  strobes_at_ack;

    snowbro2_main_bus dut (
        .clk96(clk96), .reset96(reset96), .cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata),
        .cpu_rw(cpu_rw), .cpu_as_n(cpu_as_n), .cpu_uds_n(cpu_uds_n), .cpu_lds_n(cpu_lds_n),
        .cpu_din(cpu_din), .dtack_n(dtack_n), .cen16(cen16), .cen16b(cen16b),
        .prg_cs(prg_cs), .prg_addr(prg_addr), .prg_data(prg_data), .prg_ok(prg_ok),
        .vdp_op_set_ptr(strobes[5]), .vdp_op_sel_reg(strobes[4]), .vdp_op_wr_reg(strobes[3]),
        .vdp_op_wr_ram(strobes[2]), .vdp_op_rd_ram_h(strobes[1]), .vdp_op_rd_ram_l(strobes[0]),
        .vdp_dout(vdp_dout), .vdp_ack(vdp_ack),
        .joystick1(joystick1), .joystick2(joystick2), .start_button(start_button),
        .coin_input(coin_input), .service(service), .dip_test(dip_test),
        .dipsw_a(dipsw_a), .dipsw_b(dipsw_b), .dipsw_c(dipsw_c),
        .palram_addr(palram_addr), .palram_data(palram_data), .oki_bank(oki_bank)
    );

    initial begin
        clk96 = 1'b0;
        forever #50 clk96 = ~clk96;
    end

    // program ROM with a random ready delay
    always @(posedge clk96) begin
        if (reset96 || !prg_cs) begin
            prg_ok    <= 1'b0;
            rom_delay <= $urandom_range(0, 6);
        end else if (!prg_ok) begin
            if (rom_delay == 0) begin
                if (!rom_model.exists(int'(prg_addr))) begin
                    rom_model[int'(prg_addr)] = 16'($urandom);
                end
                prg_data      <= rom_model[int'(prg_addr)];
                last_prg_addr <= prg_addr;
                prg_ok        <= 1'b1;
            end else begin
                rom_delay <= rom_delay - 1;
            end
        end
    end

    // VDP acks a pending cycle after a few clocks
    always @(posedge clk96) begin
        if (reset96 || cpu_as_n) begin
            vdp_ack   <= 1'b0;
            vdp_delay <= $urandom_range(1, 8);
        end else if (cpu_addr[23:20] == `VDP_BASE && !vdp_ack) begin
            if (vdp_delay == 0) vdp_ack <= 1'b1;
            else vdp_delay <= vdp_delay - 1;
        end
    end

    task automatic finish_run();
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    endtask

    task automatic check16(input string name, input logic [15:0] exp, input logic [15:0] act);
        checks++;
        assert (exp === act) else begin
            errors++;
            $display("Fail %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic bus_access(input logic [23:0] baddr, input logic rw, input logic [15:0] wd,
                              input logic [1:0] strb_n, output logic [15:0] rd);
        int t;
        @(posedge clk96);
        cpu_addr  <= baddr[23:1];
        cpu_wdata <= wd;
        cpu_rw    <= rw;
        cpu_uds_n <= strb_n[1];
        cpu_lds_n <= strb_n[0];
        @(posedge clk96);
        cpu_as_n <= 1'b0;
        t = 0;
        @(negedge clk96);
        while (dtack_n && t < 200) begin
            @(negedge clk96);
            t++;
        end
        if (dtack_n) begin
            errors++;
            $display("bus cycle at %h never got DTACK", baddr);
            finish_run();
        end else begin
            rd = cpu_din;
            strobes_at_ack = strobes;
            @(posedge clk96);
            cpu_as_n <= 1'b1;
            t = 0;
            @(negedge clk96);
            while (!dtack_n && t < 10) begin
                @(negedge clk96);
                t++;
            end
            if (!dtack_n) begin
                errors++;
                $display("DTACK stuck low after cycle at %h", baddr);
                finish_run();
            end
        end
    endtask

    function automatic logic [15:0] merge_lanes(input logic [15:0] old, input logic [15:0] wd,
                                                input logic [1:0] strb_n);
        return {strb_n[1] ? old[15:8] : wd[15:8], strb_n[0] ? old[7:0] : wd[7:0]};
    endfunction

    // up down left right from joystick bits 3..0
    function automatic logic [7:0] player_byte(input logic [9:0] j);
        logic [7:0] b;
        b    = 8'h00;
        b[0] = !j[3];   // up
        b[1] = !j[2];   // down
        b[2] = !j[1];   // left
        b[3] = !j[0];   // right
        b[4] = !j[4];   // button 1
        b[5] = !j[5];   // button 2
        return b;
    endfunction

    // start, coin, test and service, all active low
    function automatic logic [7:0] system_byte();
        logic [7:0] b;
        b    = 8'h00;
        b[0] = !service;
        b[2] = !dip_test;
        b[3] = !coin_input[0];
        b[4] = !coin_input[1];
        b[5] = !start_button[0];
        b[6] = !start_button[1];
        return b;
    endfunction

    // byte address, read flag, expected strobes
    function automatic logic [30:0] vdp_access_row(input int i);
        case (i)
            0:       return {24'h300000, 1'b0, 6'b100000};
            1:       return {24'h300004, 1'b0, 6'b000100};
            2:       return {24'h300006, 1'b0, 6'b000100};
            3:       return {24'h300008, 1'b0, 6'b010000};
            4:       return {24'h30000C, 1'b0, 6'b001000};
            5:       return {24'h300004, 1'b1, 6'b000010};
            6:       return {24'h300006, 1'b1, 6'b000001};
            default: return {24'h300002, 1'b0, 6'b000000};
        endcase
    endfunction

    function automatic logic [1:0] random_lanes();
        int r;
        r = $urandom_range(0, 2);
        return (r == 0) ? 2'b00 : ((r == 1) ? 2'b01 : 2'b10);
    endfunction

    task automatic ram_test(input string name, input logic [23:0] base, input logic [23:0] mask,
                            input int n, input bit pal);
        logic [23:0] pool [8];
        logic [15:0] rd;
        logic [15:0] wd;
        logic [1:0]  sn;
        int          k;
        for (int i = 0; i < n; i++) begin
            pool[i] = base | (24'($urandom) & mask & 24'hFFFFFE);
            wd = 16'($urandom);
            bus_access(pool[i], 1'b0, wd, 2'b00, rd);
            if (pal) pal_model[int'(pool[i])] = wd;
            else wram_model[int'(pool[i])] = wd;
        end
        for (int i = 0; i < 24; i++) begin
            k  = $urandom_range(0, n - 1);
            wd = 16'($urandom);
            sn = random_lanes();
            if ($urandom_range(0, 1) == 1) begin
                bus_access(pool[k], 1'b0, wd, sn, rd);
                if (pal) pal_model[int'(pool[k])] = merge_lanes(pal_model[int'(pool[k])], wd, sn);
                else wram_model[int'(pool[k])] = merge_lanes(wram_model[int'(pool[k])], wd, sn);
            end else begin
                bus_access(pool[k], 1'b1, 16'h0, 2'b00, rd);
                check16(name, pal ? pal_model[int'(pool[k])] : wram_model[int'(pool[k])], rd);
            end
        end
        for (int i = 0; i < n && pal; i++) begin
            @(posedge clk96);
            palram_addr <= pool[i][`PAL_AW:1];
            @(posedge clk96);
            @(negedge clk96);
            check16("palram port", pal_model[int'(pool[i])], palram_data);
        end
    endtask

    initial begin
        logic [23:0] ba;
        logic [15:0] rd;
        logic [15:0] wd;
        logic [1:0]  sn;
        logic [5:0]  exp_strb;
        logic        rd_dir;
        int          n16;
        int          n16b;
        int          last16;
        void'($urandom(56));
        errors = 0;
        checks = 0;
        oki_model = 1'b0;
        reset96 = 1'b1;
        cpu_addr = '0;
        cpu_wdata = '0;
        cpu_rw = 1'b1;
        cpu_as_n = 1'b1;
        cpu_uds_n = 1'b1;
        cpu_lds_n = 1'b1;
        prg_data = '0;
        prg_ok = 1'b0;
        vdp_dout = '0;
        vdp_ack = 1'b0;
        joystick1 = '0;
        joystick2 = '0;
        start_button = '0;
        coin_input = '0;
        service = 1'b0;
        dip_test = 1'b0;
        dipsw_a = '0;
        dipsw_b = '0;
        dipsw_c = '0;
        palram_addr = '0;
        repeat (5) @(posedge clk96);
        @(negedge clk96);
        check16("reset dtack_n", 16'h1, 16'(dtack_n));
        check16("reset prg_cs", 16'h0, 16'(prg_cs));
        check16("reset strobes", 16'h0, 16'(strobes));
        check16("reset oki_bank", 16'h0, 16'(oki_bank));
        check16("reset cpu_din", 16'h0, cpu_din);
        @(posedge clk96);
        reset96 <= 1'b0;
        @(negedge clk96);
        check16("first cen16", 16'h1, 16'(cen16));

        for (int i = 0; i < 12; i++) begin
            ba = 24'($urandom_range(0, `ROM_TOP)) & 24'hFFFFFE;
            bus_access(ba, 1'b1, 16'h0, 2'b00, rd);
            check16("rom prg_addr", 16'(ba[19:1]), 16'(last_prg_addr));
            check16("rom data", rom_model[int'(ba[19:1])], rd);
        end

        ram_test("work ram", 24'h100000, 24'h00FFFF, 8, 1'b0);
        ram_test("palette ram", 24'h400000, 24'h000FFF, 6, 1'b1);

        for (int r = 0; r < 4; r++) begin
            @(posedge clk96);
            joystick1    <= 10'($urandom);
            joystick2    <= 10'($urandom);
            start_button <= 2'($urandom);
            coin_input   <= 2'($urandom);
            service      <= 1'($urandom);
            dip_test     <= 1'($urandom);
            dipsw_a      <= 8'($urandom);
            dipsw_b      <= 8'($urandom);
            dipsw_c      <= 8'($urandom);
            bus_access(24'h700000, 1'b1, 16'h0, 2'b00, rd);
            check16("io jumper", {dipsw_c, dipsw_c}, rd);
            bus_access(24'h700004, 1'b1, 16'h0, 2'b00, rd);
            check16("io dsw a", {dipsw_a, dipsw_a}, rd);
            bus_access(24'h700008, 1'b1, 16'h0, 2'b00, rd);
            check16("io dsw b", {dipsw_b, dipsw_b}, rd);
            bus_access(24'h70000C, 1'b1, 16'h0, 2'b00, rd);
            check16("io p1", {2{player_byte(joystick1)}}, rd);
            bus_access(24'h700010, 1'b1, 16'h0, 2'b00, rd);
            check16("io p2", {2{player_byte(joystick2)}}, rd);
            bus_access(24'h70001C, 1'b1, 16'h0, 2'b00, rd);
            check16("io system", {8'h00, system_byte()}, rd);
        end
        bus_access(24'h700040, 1'b1, 16'h0, 2'b00, rd);
        check16("io unused offset", 16'h0, rd);
        bus_access(24'h200000 | (24'($urandom) & 24'h0FFFFE), 1'b1, 16'h0, 2'b00, rd);
        check16("unmapped read", 16'h0, rd);

        for (int i = 0; i < 8; i++) begin
            {ba, rd_dir, exp_strb} = vdp_access_row(i);
            check16("vdp idle strobes", 16'h0, 16'(strobes));
            @(posedge clk96);
            vdp_dout <= 16'($urandom);
            bus_access(ba, rd_dir, 16'($urandom), 2'b00, rd);
            check16("vdp strobe", 16'(exp_strb), 16'(strobes_at_ack));
            check16("vdp strobe cleared", 16'h0, 16'(strobes));
            if (rd_dir) check16("vdp read", vdp_dout, rd);
        end

        for (int i = 0; i < 6; i++) begin
            wd = 16'($urandom);
            sn = random_lanes();
            bus_access(24'h700030, 1'b0, wd, sn, rd);
            if (!sn[0]) oki_model = wd[0];
            check16("oki bank", 16'(oki_model), 16'(oki_bank));
        end

        n16 = 0;
        n16b = 0;
        last16 = -1;
        for (int c = 0; c < 60; c++) begin
            @(negedge clk96);
            if (cen16) begin
                n16++;
                last16 = c;
            end
            if (cen16b && last16 >= 0) check16("cen16b spacing", 16'd3, 16'(c - last16));
            if (cen16b) n16b++;
        end
        check16("cen16 count", 16'd10, 16'(n16));
        check16("cen16b count", 16'd10, 16'(n16b));

        finish_run();
    end

endmodule

`default_nettype wire
